//--- source/tile_config.svh
// tile geometry and element width macros for the matrix-vector tile engine
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// rows of the weight tile, and also the number of accumulators
`define TILE_H 4

// elements per operand word, which is the column count of the tile
`define TILE_D 4

// signed element width in bits
`define ELEM_W 8

// accumulator width, room for TILE_D full-scale products plus sign
`define ACC_W 20

`endif

//--- source/tile_data_pkg.sv
// data types for elements, operand words, accumulators and tile indices
`default_nettype none

`include "tile_config.svh"

package tile_data_pkg;

  typedef logic signed [`ELEM_W-1:0] elem_t; // one signed operand element

  // one operand word, element 0 sits in the low bits
  typedef elem_t [`TILE_D-1:0] word_t;

  typedef logic signed [`ACC_W-1:0] acc_t; // one signed accumulator

  typedef elem_t [`TILE_H-1:0] col_t; // one weight column, one element per row

  typedef acc_t [`TILE_H-1:0] acc_vec_t; // all accumulators of the tile

  // row count, wide enough to hold TILE_H itself
  typedef logic [$clog2(`TILE_H):0] row_cnt_t;

  // column count, wide enough to hold TILE_D itself
  typedef logic [$clog2(`TILE_D):0] col_cnt_t;

endpackage

`default_nettype wire

//--- source/tile_ctrl_pkg.sv
// control types for the job sequencer state and the operand routing select
`default_nettype none

package tile_ctrl_pkg;

  // job sequencer states
  typedef enum logic [2:0] {
    S_IDLE   = 3'd0, // waiting for the first weight word of a job
    S_LOAD_W = 3'd1, // taking weight rows until the buffer reports all rows loaded
    S_LOAD_X = 3'd2, // taking the x vector word
    S_SHIFT  = 3'd3, // one accumulate per cycle, TILE_D cycles
    S_DRAIN  = 3'd4  // results go out over the result port
  } seq_state_e;

  // where a taken operand word is routed
  typedef enum logic {
    OP_WEIGHT = 1'b0, // into the weight buffer at the row pointer
    OP_VECTOR = 1'b1  // into the x shift register of the mac row
  } operand_e;

endpackage

`default_nettype wire

//--- source/word_ingress.sv
// four-phase operand receiver holding one word until the sequencer takes it
`timescale 1ns/1ps
`default_nettype none

module word_ingress (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 in_req_i,
  input  wire tile_data_pkg::word_t in_data_i,
  output logic                      in_ack_o,
  input  wire logic                 take_i,
  output logic                      word_valid_o,
  output tile_data_pkg::word_t      word_o
);

  logic                 ack_q;   // ack toward the upstream sender
  logic                 valid_q; // a captured word waits for the sequencer
  logic                 capture; // a fresh request is seen and the holding slot is free
  tile_data_pkg::word_t word_q;

  // a new request is only accepted while ack is low, so the same word is never taken twice
  assign capture = in_req_i && !ack_q && !valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      valid_q <= 1'b0;
    end else if (take_i) begin
      valid_q <= 1'b0; // slot frees on the cycle after the take
      ack_q   <= 1'b1; // ack follows the take by one cycle
    end else if (capture) begin
      valid_q <= 1'b1;
    end else if (ack_q && !in_req_i) begin
      ack_q   <= 1'b0; // sender dropped req, close the four-phase cycle
    end
  end

  // word register is payload and only written on capture
  always_ff @(posedge clk_i) begin
    if (capture) begin
      word_q <= in_data_i;
    end
  end

  assign in_ack_o     = ack_q;
  assign word_valid_o = valid_q;
  assign word_o       = word_q;

  // ack only ever rises as the answer to a pending request
  a_ack_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(in_ack_o) |-> in_req_i
  );

endmodule

`default_nettype wire

//--- source/w_buffer.sv
// weight store with row-pointer loading, column masking and column shifting
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module w_buffer (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    clear_i,
  input  wire logic                    load_i,
  input  wire logic                    shift_i,
  input  wire tile_data_pkg::word_t    w_row_i,
  input  wire tile_data_pkg::row_cnt_t rows_valid_i,
  input  wire tile_data_pkg::col_cnt_t cols_valid_i,
  output tile_data_pkg::col_t          w_col_o,
  output logic                         rows_done_o
);

  tile_data_pkg::word_t [`TILE_H-1:0] w_q;     // one word per tile row
  tile_data_pkg::row_cnt_t            row_ptr_q; // next row to be loaded
  tile_data_pkg::word_t               row_masked;

  // columns at or beyond cols_valid_i are forced to zero before storing
  always_comb begin
    for (int d = 0; d < `TILE_D; d++) begin
      row_masked[d] = (d < int'(cols_valid_i)) ? w_row_i[d] : '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_q <= '0; // rows that are never loaded must read as zero
    end else if (clear_i) begin
      w_q <= '0;
    end else if (load_i) begin
      if (row_ptr_q < tile_data_pkg::row_cnt_t'(`TILE_H)) begin
        w_q[row_ptr_q] <= row_masked;
      end
    end else if (shift_i) begin
      // every row moves one step toward column 0, top column fills with zero
      for (int h = 0; h < `TILE_H; h++) begin
        for (int d = 0; d < `TILE_D; d++) begin
          w_q[h][d] <= (d < `TILE_D - 1) ? w_q[h][d+1] : '0;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_ptr_q <= '0;
    end else if (clear_i) begin
      row_ptr_q <= '0; // next job starts again at row 0
    end else if (load_i) begin
      row_ptr_q <= row_ptr_q + 1'b1;
    end
  end

  // the sequencer stops loading here, so the pointer never runs past rows_valid_i
  assign rows_done_o = (row_ptr_q == rows_valid_i);

  // column 0 of each row feeds the matching accumulator
  always_comb begin
    for (int h = 0; h < `TILE_H; h++) begin
      w_col_o[h] = w_q[h][0];
    end
  end

  a_no_load_and_shift : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(load_i && shift_i)
  );

endmodule

`default_nettype wire

//--- source/mac_row.sv
// x shift register and TILE_H signed multiply-accumulators
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module mac_row (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 clear_i,
  input  wire logic                 x_load_i,
  input  wire logic                 acc_en_i,
  input  wire tile_data_pkg::word_t x_i,
  input  wire tile_data_pkg::col_t  w_col_i,
  output tile_data_pkg::acc_vec_t   acc_o
);

  tile_data_pkg::word_t    x_q;   // x vector, element 0 is the one in use
  tile_data_pkg::acc_vec_t acc_q; // running sums, one per tile row
  tile_data_pkg::acc_vec_t prod;  // this cycle's products, sign extended

  // each row multiplies its own weight by the shared x head
  always_comb begin
    for (int h = 0; h < `TILE_H; h++) begin
      prod[h] = $signed(w_col_i[h]) * $signed(x_q[0]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_q <= '0;
    end else if (clear_i) begin
      x_q <= '0;
    end else if (x_load_i) begin
      x_q <= x_i;
    end else if (acc_en_i) begin
      // x steps in lock with the weight columns
      for (int d = 0; d < `TILE_D; d++) begin
        x_q[d] <= (d < `TILE_D - 1) ? x_q[d+1] : '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0; // no sum survives into the next job
    end else if (acc_en_i) begin
      for (int h = 0; h < `TILE_H; h++) begin
        acc_q[h] <= $signed(acc_q[h]) + $signed(prod[h]);
      end
    end
  end

  assign acc_o = acc_q;

endmodule

`default_nettype wire

//--- source/tile_sequencer.sv
// job FSM that routes operand words and counts the shift cycles
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module tile_sequencer (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic word_valid_i,
  output logic      take_o,
  input  wire logic rows_done_i,
  output logic      w_load_o,
  output logic      x_load_o,
  output logic      shift_o,
  output logic      clear_o,
  output logic      drain_start_o,
  output logic      busy_o,
  input  wire logic drain_done_i
);

  tile_ctrl_pkg::seq_state_e state_q, state_d;
  tile_ctrl_pkg::operand_e   op_sel;       // where a word taken now goes
  tile_data_pkg::col_cnt_t   shift_cnt_q;  // shift cycles done in this job
  logic                      shift_last;   // final shift cycle of the job
  logic                      can_take;
  logic                      drain_start_q;

  // words are only accepted while loading, never during shift or drain
  assign can_take = (state_q == tile_ctrl_pkg::S_IDLE) ||
                    (state_q == tile_ctrl_pkg::S_LOAD_W && !rows_done_i) ||
                    (state_q == tile_ctrl_pkg::S_LOAD_X);
  assign take_o   = word_valid_i && can_take;

  // everything before the x state is a weight row
  assign op_sel   = (state_q == tile_ctrl_pkg::S_LOAD_X) ? tile_ctrl_pkg::OP_VECTOR
                                                         : tile_ctrl_pkg::OP_WEIGHT;
  assign w_load_o = take_o && (op_sel == tile_ctrl_pkg::OP_WEIGHT);
  assign x_load_o = take_o && (op_sel == tile_ctrl_pkg::OP_VECTOR);

  assign shift_o    = (state_q == tile_ctrl_pkg::S_SHIFT);
  assign shift_last = (shift_cnt_q == tile_data_pkg::col_cnt_t'(`TILE_D - 1));
  assign clear_o    = (state_q == tile_ctrl_pkg::S_DRAIN) && drain_done_i; // job end
  assign busy_o     = take_o || (state_q != tile_ctrl_pkg::S_IDLE);
  assign drain_start_o = drain_start_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      tile_ctrl_pkg::S_IDLE:   if (take_o) state_d = tile_ctrl_pkg::S_LOAD_W;
      tile_ctrl_pkg::S_LOAD_W: if (rows_done_i) state_d = tile_ctrl_pkg::S_LOAD_X;
      tile_ctrl_pkg::S_LOAD_X: if (take_o) state_d = tile_ctrl_pkg::S_SHIFT;
      tile_ctrl_pkg::S_SHIFT:  if (shift_last) state_d = tile_ctrl_pkg::S_DRAIN;
      tile_ctrl_pkg::S_DRAIN:  if (drain_done_i) state_d = tile_ctrl_pkg::S_IDLE;
      default:                 state_d = tile_ctrl_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= tile_ctrl_pkg::S_IDLE;
      shift_cnt_q   <= '0;
      drain_start_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      drain_start_q <= shift_o && shift_last; // first cycle of S_DRAIN
      if (shift_o) begin
        // wraps to zero on the last shift, ready for the next job
        shift_cnt_q <= shift_last ? '0 : shift_cnt_q + 1'b1;
      end
    end
  end

  // one unbroken run of TILE_D accumulate cycles per job
  a_shift_run : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(shift_o) |-> shift_o [*`TILE_D] ##1 !shift_o
  );

endmodule

`default_nettype wire

//--- source/result_egress.sv
// four-phase result sender that serializes the accumulators in row order
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module result_egress (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    drain_start_i,
  input  wire tile_data_pkg::acc_vec_t acc_i,
  output logic                         res_req_o,
  output tile_data_pkg::acc_t          res_data_o,
  input  wire logic                    res_ack_i,
  output logic                         drain_done_o
);

  tile_data_pkg::acc_vec_t snap_q;   // frozen copy of the accumulators
  tile_data_pkg::row_cnt_t idx_q;    // row currently on the port
  logic                    active_q; // a drain is in progress
  logic                    req_q;
  logic                    done_q;
  logic                    idx_last;

  assign idx_last = (idx_q == tile_data_pkg::row_cnt_t'(`TILE_H - 1));

  always_ff @(posedge clk_i) begin
    if (drain_start_i) begin
      snap_q <= acc_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      req_q    <= 1'b0;
      idx_q    <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (drain_start_i) begin
        active_q <= 1'b1;
        req_q    <= 1'b1; // row 0 goes out on the next cycle
        idx_q    <= '0;
      end else if (req_q && res_ack_i) begin
        req_q <= 1'b0; // receiver has the value, drop req
      end else if (active_q && !req_q && !res_ack_i) begin
        // ack has fallen, the four-phase cycle for this row is complete
        if (idx_last) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end else begin
          idx_q <= idx_q + 1'b1;
          req_q <= 1'b1;
        end
      end
    end
  end

  assign res_req_o    = req_q;
  assign res_data_o   = snap_q[idx_q];
  assign drain_done_o = done_q;

  // data may only change while req is low
  a_data_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    res_req_o && $past(res_req_o) |-> $stable(res_data_o)
  );

endmodule

`default_nettype wire

//--- source/matvec_tile_top.sv
// top level of the matrix-vector tile engine, instances and wiring only
`timescale 1ns/1ps
`default_nettype none

module matvec_tile_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    in_req_i,
  input  wire tile_data_pkg::word_t    in_data_i,
  output logic                         in_ack_o,
  input  wire tile_data_pkg::row_cnt_t rows_valid_i,
  input  wire tile_data_pkg::col_cnt_t cols_valid_i,
  output logic                         res_req_o,
  output tile_data_pkg::acc_t          res_data_o,
  input  wire logic                    res_ack_i,
  output logic                         busy_o
);

  tile_data_pkg::word_t    word;       // operand word waiting in the ingress
  tile_data_pkg::col_t     w_col;      // weight column in front of the mac row
  tile_data_pkg::acc_vec_t acc;
  logic                    word_valid;
  logic                    take;
  logic                    rows_done;
  logic                    w_load;
  logic                    x_load;
  logic                    shift;      // also the accumulate enable
  logic                    clear;
  logic                    drain_start;
  logic                    drain_done;

  word_ingress u_word_ingress (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_req_i     (in_req_i),
    .in_data_i    (in_data_i),
    .in_ack_o     (in_ack_o),
    .take_i       (take),
    .word_valid_o (word_valid),
    .word_o       (word)
  );

  tile_sequencer u_tile_sequencer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .word_valid_i  (word_valid),
    .take_o        (take),
    .rows_done_i   (rows_done),
    .w_load_o      (w_load),
    .x_load_o      (x_load),
    .shift_o       (shift),
    .clear_o       (clear),
    .drain_start_o (drain_start),
    .busy_o        (busy_o),
    .drain_done_i  (drain_done)
  );

  // the same word bus feeds both the weight rows and the x vector
  w_buffer u_w_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear),
    .load_i       (w_load),
    .shift_i      (shift),
    .w_row_i      (word),
    .rows_valid_i (rows_valid_i),
    .cols_valid_i (cols_valid_i),
    .w_col_o      (w_col),
    .rows_done_o  (rows_done)
  );

  mac_row u_mac_row (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear),
    .x_load_i (x_load),
    .acc_en_i (shift),
    .x_i      (word),
    .w_col_i  (w_col),
    .acc_o    (acc)
  );

  result_egress u_result_egress (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .drain_start_i (drain_start),
    .acc_i         (acc),
    .res_req_o     (res_req_o),
    .res_data_o    (res_data_o),
    .res_ack_i     (res_ack_i),
    .drain_done_o  (drain_done)
  );

endmodule

`default_nettype wire

//--- dv/tb_matvec_tile.sv
// testbench for the matrix-vector tile engine with reference model and checking assertions
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module tb_matvec_tile;

  localparam int TIMEOUT_CYC = 2000; // upper bound for any single wait loop

  logic                    clk_i;
  logic                    rst_ni;
  logic                    in_req_i;
  tile_data_pkg::word_t    in_data_i;
  logic                    in_ack_o;
  tile_data_pkg::row_cnt_t rows_valid_i;
  tile_data_pkg::col_cnt_t cols_valid_i;
  logic                    res_req_o;
  tile_data_pkg::acc_t     res_data_o;
  logic                    res_ack_i;
  logic                    busy_o;

  int    errors;        // every failed check adds one
  bit    timeout_hit;   // a handshake partner stopped answering
  logic  in_drain;      // high from the first result request until the last ack of a job drops
  int    max_ack_delay; // upper bound of the random result ack delay in cycles
  string test_name;

  tile_data_pkg::word_t word_q[$]; // operand words still to send, all queued jobs in order
  int                   exp_q[$];  // expected results in port order

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i; // 8 ns period
  end

  matvec_tile_top u_matvec_tile_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_req_i     (in_req_i),
    .in_data_i    (in_data_i),
    .in_ack_o     (in_ack_o),
    .rows_valid_i (rows_valid_i),
    .cols_valid_i (cols_valid_i),
    .res_req_o    (res_req_o),
    .res_data_o   (res_data_o),
    .res_ack_i    (res_ack_i),
    .busy_o       (busy_o)
  );

  // ack may stay up for the one cycle after req drops, never longer
  a_in_ack_window : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_ack_o |-> (in_req_i || $past(in_req_i))
  ) else begin
    $display("in_ack_o is high although in_req_i has been low for more than a cycle");
    errors = errors + 1;
  end

  a_res_data_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    res_req_o && $past(res_req_o) |-> $stable(res_data_o)
  ) else begin
    $display("res_data_o changed while res_req_o stayed high");
    errors = errors + 1;
  end

  // the engine must not accept a new operand while results go out
  a_no_ack_in_drain : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(in_ack_o) |-> !in_drain
  ) else begin
    $display("in_ack_o rose while results of a job were still being drained");
    errors = errors + 1;
  end

  a_busy_in_drain : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    res_req_o |-> busy_o
  ) else begin
    $display("busy_o was low while a result request was pending");
    errors = errors + 1;
  end

  // queues one job and its expected y, masked columns and unloaded rows count as zero
  task automatic make_job(input int rows, input int cols);
    tile_data_pkg::word_t w_rows [`TILE_H];
    tile_data_pkg::word_t x;
    int                   sum;
    for (int h = 0; h < rows; h++) begin
      for (int d = 0; d < `TILE_D; d++) begin
        w_rows[h][d] = tile_data_pkg::elem_t'($urandom_range(255, 0)); // also beyond cols
      end
      word_q.push_back(w_rows[h]);
    end
    for (int d = 0; d < `TILE_D; d++) begin
      x[d] = tile_data_pkg::elem_t'($urandom_range(255, 0));
    end
    word_q.push_back(x); // the x vector follows the last weight row
    for (int h = 0; h < `TILE_H; h++) begin
      sum = 0;
      for (int d = 0; d < cols && h < rows; d++) begin
        sum += int'($signed(w_rows[h][d])) * int'($signed(x[d]));
      end
      exp_q.push_back(sum);
    end
  endtask

  // four-phase sender for the operand port
  task automatic send_words(input int count);
    tile_data_pkg::word_t w;
    int                   wait_cyc;
    for (int n = 0; n < count && !timeout_hit; n++) begin
      w = word_q.pop_front();
      @(posedge clk_i);
      in_data_i <= w;
      in_req_i  <= 1'b1;
      wait_cyc = 0;
      while (in_ack_o !== 1'b1 && wait_cyc < TIMEOUT_CYC) begin
        @(posedge clk_i);
        wait_cyc++;
      end
      in_req_i <= 1'b0; // data stays on the bus, only req drops
      if (wait_cyc >= TIMEOUT_CYC) begin
        $display("timeout in %s: operand word %0d never got an ack", test_name, n);
        errors = errors + 1;
        timeout_hit = 1'b1;
      end
      wait_cyc = 0;
      while (in_ack_o !== 1'b0 && wait_cyc < TIMEOUT_CYC && !timeout_hit) begin
        @(posedge clk_i);
        wait_cyc++;
      end
      if (wait_cyc >= TIMEOUT_CYC) begin
        $display("timeout in %s: in_ack_o stayed high after req dropped", test_name);
        errors = errors + 1;
        timeout_hit = 1'b1;
      end
    end
  endtask

  // four-phase receiver for the result port with random ack delays
  task automatic receive_results(input int count);
    int wait_cyc;
    int expected;
    for (int n = 0; n < count && !timeout_hit; n++) begin
      expected = exp_q.pop_front();
      wait_cyc = 0;
      while (res_req_o !== 1'b1 && wait_cyc < TIMEOUT_CYC && !timeout_hit) begin
        @(posedge clk_i);
        wait_cyc++;
      end
      if (wait_cyc >= TIMEOUT_CYC) begin
        $display("timeout in %s: result %0d was never requested", test_name, n);
        errors = errors + 1;
        timeout_hit = 1'b1;
      end else if (!timeout_hit) begin
        in_drain <= 1'b1;
        assert (int'(res_data_o) == expected) else begin
          $display("[FAIL] %s row %0d: expected %0d actual %0d", test_name,
                   n % `TILE_H, expected, int'(res_data_o));
          errors = errors + 1;
        end
        repeat ($urandom_range(max_ack_delay, 0)) @(posedge clk_i);
        res_ack_i <= 1'b1;
        wait_cyc = 0;
        while (res_req_o !== 1'b0 && wait_cyc < TIMEOUT_CYC) begin
          @(posedge clk_i);
          wait_cyc++;
        end
        if (wait_cyc >= TIMEOUT_CYC) begin
          $display("timeout in %s: res_req_o stayed high after the ack", test_name);
          errors = errors + 1;
          timeout_hit = 1'b1;
        end
        repeat ($urandom_range(max_ack_delay, 0)) @(posedge clk_i);
        res_ack_i <= 1'b0;
        if (n % `TILE_H == `TILE_H - 1) begin
          in_drain <= 1'b0; // last result of this job is handed over
        end
      end
    end
  endtask

  // runs back-to-back jobs with one geometry, the sender runs ahead into the drain
  task automatic run_jobs(input string name, input int rows, input int cols,
                          input int jobs, input int ack_delay);
    int wait_cyc;
    if (!timeout_hit) begin
      test_name     = name;
      max_ack_delay = ack_delay;
      @(posedge clk_i);
      rows_valid_i <= tile_data_pkg::row_cnt_t'(rows);
      cols_valid_i <= tile_data_pkg::col_cnt_t'(cols);
      for (int j = 0; j < jobs; j++) begin
        make_job(rows, cols);
      end
      fork
        send_words(jobs * (rows + 1));
        receive_results(jobs * `TILE_H);
      join
      wait_cyc = 0;
      while (busy_o !== 1'b0 && wait_cyc < TIMEOUT_CYC && !timeout_hit) begin
        @(posedge clk_i);
        wait_cyc++;
      end
      if (wait_cyc >= TIMEOUT_CYC) begin
        $display("timeout in %s: busy_o never fell after the last result", test_name);
        errors = errors + 1;
        timeout_hit = 1'b1;
      end
    end
  endtask

  initial begin
    void'($urandom(57208));
    errors       = 0;
    timeout_hit  = 1'b0;
    in_drain     = 1'b0;
    rst_ni       = 1'b0;
    in_req_i     = 1'b0;
    in_data_i    = '0;
    rows_valid_i = tile_data_pkg::row_cnt_t'(`TILE_H);
    cols_valid_i = tile_data_pkg::col_cnt_t'(`TILE_D);
    res_ack_i    = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    // handshake outputs and busy must come out of reset low
    assert ({in_ack_o, res_req_o, busy_o} == 3'b000) else begin
      $display("[FAIL] reset: expected 000 actual %b", {in_ack_o, res_req_o, busy_o});
      errors = errors + 1;
    end
    run_jobs("full_tile", `TILE_H, `TILE_D, 4, 2);
    run_jobs("col_mask", `TILE_H, $urandom_range(`TILE_D - 1, 1), 3, 2);
    run_jobs("row_mask", $urandom_range(`TILE_H - 1, 1), `TILE_D, 3, 2);
    run_jobs("row_col_mask", 1, 1, 2, 1);
    run_jobs("back_pressure", `TILE_H, `TILE_D, 3, 25); // long acks stall the drain
    run_jobs("back_pressure_mask", 2, 3, 2, 25);
    $display("run complete, errors: %0d", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/tile_data_pkg.sv
source/tile_ctrl_pkg.sv
source/word_ingress.sv
source/w_buffer.sv
source/mac_row.sv
source/tile_sequencer.sv
source/result_egress.sv
source/matvec_tile_top.sv
dv/tb_matvec_tile.sv

//--- run.sh
#!/usr/bin/env bash
# builds the matrix-vector tile testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module tb_matvec_tile \
  -o tb_matvec_tile

sim_out=$(./obj_dir/tb_matvec_tile)
echo "$sim_out"

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
  exit 0
fi
exit 1
